// ==== tests/mem_stimulus.txt ====
# op (R or W), byte address hex, write data hex, hit expected on first cycle (1 or 0)
# address fields: tag [15:11], set [10:4], word [3:1]
R 0050 0000 0
R 0050 0000 1
R 0052 0000 1
R 005e 0000 1
R 0058 0000 1
W 0054 beef 1
R 0054 0000 1
R 1854 0000 0
R 185e 0000 1
R 0054 0000 0
R 0052 0000 1
W 0896 1234 0
R 0896 0000 1
R 0890 0000 1
W 1852 a5a5 0
R 1852 0000 1
R 0050 0000 0
R fff0 0000 0
W fffe 0f0f 1
R fffe 0000 1
R 085e 0000 0
R 1852 0000 0
W 1800 7777 0
R 1800 0000 1
R 0000 0000 0
R 1800 0000 0
R 0002 0000 0

// ==== list.f ====
hw/cache_pkg.sv
hw/cache_fill_fsm.sv
hw/meta_data_array.sv
hw/data_array.sv
hw/cache.sv
hw/main_memory.sv
hw/mem_subsystem.sv
tests/tb_mem_subsystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run from the project root so the stimulus path resolves
cd "$(dirname "$0")" &&
verilator --binary --timing -sv -f list.f --top-module tb_mem_subsystem -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "simulation did not complete successfully"; exit 1; }

// ==== tests/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;
	import cache_pkg::*;

	localparam int    MEM_LATENCY = 4;                    // same default as the top level
	localparam int    WAIT_LIMIT  = 100;                  // cycles allowed for any one wait
	localparam string STIM_FILE   = "tests/mem_stimulus.txt";

	logic              clk;
	logic              rst_n;
	logic              mem_read;
	logic              mem_write;
	logic [ADDR_W-1:0] read_addr;
	logic [ADDR_W-1:0] write_addr;
	logic [DATA_W-1:0] write_data;
	logic [DATA_W-1:0] read_data;
	logic              hit;
	logic              miss;
	logic              busy;
	logic              finish;

	logic [DATA_W-1:0] shadow_mem [1 << (ADDR_W - 1)];    // what main memory should hold
	logic              shadow_valid [NUM_SETS];           // which sets hold a block
	logic [TAG_W-1:0]  shadow_tag [NUM_SETS];             // tag of the resident block

	mem_subsystem #(
		.MEM_LATENCY (MEM_LATENCY)
	) mem_subsystem_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.read_data  (read_data),
		.hit        (hit),
		.miss       (miss),
		.busy       (busy),
		.finish     (finish)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;                                // 40 ns period

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
			stop_run();
		end
	endtask

	// finish pulses once the tag is written
	task automatic wait_for_finish();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!finish) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout waiting for finish");
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	// held request turns into a hit after the fill
	task automatic wait_for_hit();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!hit) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("timeout waiting for hit after the fill");
				stop_run();
			end
			@(negedge clk);
		end
	endtask

	// one processor access, held until hit
	task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input logic exp_hit);
		addr_fields_t      fields;
		logic [ADDR_W-2:0] widx;
		logic              predicted;
		fields    = addr_fields_t'(addr);
		widx      = addr[ADDR_W-1:1];                     // word index, byte bit dropped
		predicted = shadow_valid[fields.set_index] && (shadow_tag[fields.set_index] == fields.tag);
		check_value("expected_hit", 32'(exp_hit), 32'(predicted)); // file agrees with tag table
		@(posedge clk);
		#2;
		mem_read   = !is_write;
		mem_write  = is_write;
		read_addr  = is_write ? 16'h0000 : addr;
		write_addr = is_write ? addr : 16'h0000;
		write_data = is_write ? wdata : 16'h0000;
		@(negedge clk);                                   // combinational outputs settled
		check_value("busy", 32'(busy), 32'd0);
		check_value("hit", 32'(hit), 32'(exp_hit));
		check_value("miss", 32'(miss), 32'(!exp_hit));
		if (!hit) begin
			wait_for_finish();
			check_value("busy", 32'(busy), 32'd1);        // still busy in the tag write cycle
			wait_for_hit();
			shadow_valid[fields.set_index] = 1'b1;        // block now resident
			shadow_tag[fields.set_index]   = fields.tag;
		end
		check_value("busy", 32'(busy), 32'd0);
		check_value("miss", 32'(miss), 32'd0);
		if (is_write) begin
			shadow_mem[widx] = wdata;                     // cache and memory take it at the edge
		end else begin
			check_value("read_data", 32'(read_data), 32'(shadow_mem[widx]));
		end
		@(posedge clk);
		#2;
		mem_read  = 1'b0;                                 // one idle cycle between accesses
		mem_write = 1'b0;
		@(negedge clk);
		check_value("busy", 32'(busy), 32'd0);
		check_value("finish", 32'(finish), 32'd0);
		check_value("hit", 32'(hit), 32'd0);
	endtask

	initial begin
		int                fd;
		int                n;
		int                line_no;
		int                accesses;
		string             line;
		byte               op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic [31:0]       exp_flag;
		rst_n      = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		read_addr  = '0;
		write_addr = '0;
		write_data = '0;
		line_no    = 0;
		accesses   = 0;
		for (int i = 0; i < (1 << (ADDR_W - 1)); i++) begin
			shadow_mem[i] = DATA_W'(i) ^ 16'h5a5a;        // memory init rule
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			shadow_valid[s] = 1'b0;
			shadow_tag[s]   = '0;
		end
		repeat (3) @(posedge clk);                        // reset held 3 cycles
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("busy", 32'(busy), 32'd0);
		check_value("finish", 32'(finish), 32'd0);
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("could not open stimulus file %s", STIM_FILE);
			stop_run();
		end
		while (!$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			line_no++;
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;                                 // blank or comment line
			end
			n = $sscanf(line, "%c %h %h %h", op, addr, wdata, exp_flag);
			if (n != 4 || (op != "R" && op != "W")) begin
				$display("stimulus line %0d could not be parsed", line_no);
				stop_run();
			end
			run_access(op == "W", addr, wdata, exp_flag[0]);
			accesses++;
		end
		$fclose(fd);
		if (accesses == 0) begin
			$display("stimulus file held no accesses");
			stop_run();
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== hw/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int MEM_LATENCY = 4                    // passed to main memory
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mem_read,   // processor read, held until hit
	input  logic                         mem_write,  // processor write, held until hit
	input  logic [cache_pkg::ADDR_W-1:0] read_addr,
	input  logic [cache_pkg::ADDR_W-1:0] write_addr,
	input  logic [cache_pkg::DATA_W-1:0] write_data,
	output logic [cache_pkg::DATA_W-1:0] read_data,  // valid in a hit cycle
	output logic                         hit,
	output logic                         miss,
	output logic                         busy,
	output logic                         finish
);
	import cache_pkg::*;

	mem_req_t          mem_req;                      // cache to memory command
	logic [DATA_W-1:0] mem_rdata;                    // fill data back to cache
	logic              mem_rvalid;

	cache cache_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.read_addr  (read_addr),
		.write_addr (write_addr),
		.write_data (write_data),
		.mem_rdata  (mem_rdata),
		.mem_rvalid (mem_rvalid),
		.read_data  (read_data),
		.hit        (hit),
		.miss       (miss),
		.busy       (busy),
		.finish     (finish),
		.mem_req    (mem_req)
	);

	main_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) main_memory_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (mem_req),
		.rdata  (mem_rdata),
		.rvalid (mem_rvalid)
	);

endmodule

// ==== hw/main_memory.sv ====
`timescale 1ns/1ps

module main_memory #(
	parameter int MEM_LATENCY = 4                  // request to rvalid in cycles
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  cache_pkg::mem_req_t          req,      // read or write command
	output logic [cache_pkg::DATA_W-1:0] rdata,    // read data after MEM_LATENCY
	output logic                         rvalid    // one cycle per read
);
	import cache_pkg::*;

	localparam int MEM_WORDS = 1 << (ADDR_W - 1);  // word addressed by addr[15:1]
	localparam logic [DATA_W-1:0] INIT_PATTERN = 16'h5a5a;

	logic [DATA_W-1:0]      mem [MEM_WORDS];
	logic [ADDR_W-2:0]      word_idx;              // byte address without bit 0
	logic [MEM_LATENCY-1:0] vld_pipe;              // read valid shift register
	logic [DATA_W-1:0]      data_pipe [MEM_LATENCY]; // read data rides beside it

	assign word_idx = req.addr[ADDR_W-1:1];

	// storage with a fixed init pattern on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= DATA_W'(i) ^ INIT_PATTERN;  // index xor pattern
			end
		end else if (req.write) begin
			mem[word_idx] <= req.wdata;               // single cycle write
		end
	end

	// valid pipeline, several reads can be in flight
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= req.read;
			for (int i = 1; i < MEM_LATENCY; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
		end
	end

	// data pipeline, array is sampled in the request cycle
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[word_idx];
		for (int i = 1; i < MEM_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign rvalid = vld_pipe[MEM_LATENCY-1];
	assign rdata  = data_pipe[MEM_LATENCY-1];

endmodule

// ==== hw/cache.sv ====
`timescale 1ns/1ps

module cache (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mem_read,   // held until hit
	input  logic                         mem_write,  // held until hit
	input  logic [cache_pkg::ADDR_W-1:0] read_addr,
	input  logic [cache_pkg::ADDR_W-1:0] write_addr,
	input  logic [cache_pkg::DATA_W-1:0] write_data,
	input  logic [cache_pkg::DATA_W-1:0] mem_rdata,  // fill word from memory
	input  logic                         mem_rvalid, // fill word valid
	output logic [cache_pkg::DATA_W-1:0] read_data,
	output logic                         hit,
	output logic                         miss,
	output logic                         busy,       // fill in progress
	output logic                         finish,     // one cycle pulse at end of fill
	output cache_pkg::mem_req_t          mem_req     // fill reads and write-through
);
	import cache_pkg::*;

	addr_fields_t      req_addr;         // processor address split into fields
	addr_fields_t      fill_addr;        // block address from the fill FSM
	logic              request;          // any processor access present
	logic              tag_match;        // resident block is the requested one
	logic              fill_read;
	logic              fill_write_data;
	logic              write_tag;
	logic [WORD_W-1:0] fill_word;
	logic [SET_W-1:0]  set_index;        // steered array index
	logic [WORD_W-1:0] word_sel;         // steered word index
	logic [DATA_W-1:0] data_din;
	logic              data_we;
	logic              write_hit;
	logic [DATA_W-1:0] data_dout_w;
	meta_entry_t       meta_din;
	meta_entry_t       meta_dout;

	// the write address wins when writing
	assign req_addr = mem_write ? addr_fields_t'(write_addr) : addr_fields_t'(read_addr);
	assign request  = mem_read | mem_write;

	// array index comes from the fill FSM while a fill runs
	assign set_index = busy ? fill_addr.set_index : req_addr.set_index;
	assign word_sel  = busy ? fill_word : req_addr.word_sel;

	assign tag_match = meta_dout.valid && (meta_dout.tag == req_addr.tag);
	assign hit       = request && tag_match && !busy;
	assign miss      = request && !tag_match && !busy;  // repeat misses ignored while filling
	assign write_hit = hit && mem_write;

	// data array takes fill words or the processor write
	assign data_din = busy ? mem_rdata : write_data;
	assign data_we  = fill_write_data | write_hit;

	always_comb begin
		meta_din.valid = 1'b1;                   // only written at end of a fill
		meta_din.tag   = fill_addr.tag;
	end

	assign finish    = write_tag;
	assign read_data = data_dout_w;

	// memory command
	always_comb begin
		mem_req.read  = fill_read;
		mem_req.write = write_hit;               // write-through in the hit cycle
		mem_req.addr  = fill_read ? ADDR_W'(fill_addr) : write_addr;
		mem_req.wdata = write_data;
	end

	cache_fill_fsm fill_fsm_inst (
		.clk             (clk),
		.rst_n           (rst_n),
		.miss            (miss),
		.miss_addr       (req_addr),
		.mem_rvalid      (mem_rvalid),
		.busy            (busy),
		.fill_read       (fill_read),
		.fill_write_data (fill_write_data),
		.write_tag       (write_tag),
		.fill_addr       (fill_addr),
		.fill_word       (fill_word)
	);

	meta_data_array meta_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.set_index (set_index),
		.write     (write_tag),
		.din       (meta_din),
		.dout      (meta_dout)
	);

	data_array data_inst (
		.clk       (clk),
		.set_index (set_index),
		.word_sel  (word_sel),
		.write     (data_we),
		.din       (data_din),
		.dout      (data_dout_w)
	);

endmodule

// ==== hw/data_array.sv ====
`timescale 1ns/1ps

module data_array (
	input  logic                         clk,
	input  logic [cache_pkg::SET_W-1:0]  set_index, // line select
	input  logic [cache_pkg::WORD_W-1:0] word_sel,  // word within the line
	input  logic                         write,     // fill word or write hit
	input  logic [cache_pkg::DATA_W-1:0] din,       // word to store
	output logic [cache_pkg::DATA_W-1:0] dout       // addressed word
);
	import cache_pkg::*;

	logic [DATA_W-1:0] words [NUM_SETS][WORDS_PER_BLOCK]; // 128 lines of 8 words

	// one word written per edge
	always_ff @(posedge clk) begin
		if (write) begin
			words[set_index][word_sel] <= din;
		end
	end

	assign dout = words[set_index][word_sel];           // combinational read for hits

endmodule

// ==== hw/meta_data_array.sv ====
`timescale 1ns/1ps

module meta_data_array (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [cache_pkg::SET_W-1:0] set_index, // line to read or write
	input  logic                        write,     // tag write strobe
	input  cache_pkg::meta_entry_t      din,       // valid plus new tag
	output cache_pkg::meta_entry_t      dout       // addressed entry
);
	import cache_pkg::*;

	meta_entry_t entries [NUM_SETS];               // one entry per set

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_SETS; i++) begin
				entries[i].valid <= 1'b0;          // every line starts invalid
			end
		end else if (write) begin
			entries[set_index] <= din;             // tag and valid land together
		end
	end

	// read straight out of the array so hit is known in the request cycle
	assign dout = entries[set_index];

endmodule

// ==== hw/cache_fill_fsm.sv ====
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         miss,            // combinational miss from cache
	input  cache_pkg::addr_fields_t      miss_addr,       // address of the missing access
	input  logic                         mem_rvalid,      // one returned word this cycle
	output logic                         busy,            // high from fill start to finish
	output logic                         fill_read,       // read strobe toward memory
	output logic                         fill_write_data, // write returned word into data array
	output logic                         write_tag,       // write tag and valid at end of fill
	output cache_pkg::addr_fields_t      fill_addr,       // block address plus request word
	output logic [cache_pkg::WORD_W-1:0] fill_word        // word slot of returned data
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		IDLE,                                   // waiting for a miss
		FILL,                                   // requests and returns in flight
		DONE                                    // tag write cycle
	} state_t;

	localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(WORDS_PER_BLOCK - 1);

	state_t            state;
	logic [TAG_W-1:0]  blk_tag;                 // latched tag of the block being filled
	logic [SET_W-1:0]  blk_set;                 // latched set of the block being filled
	logic [WORD_W-1:0] req_cnt;                 // next word to request
	logic              req_active;              // still issuing reads
	logic [WORD_W-1:0] rcv_cnt;                 // next word expected back

	// control state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			req_active <= 1'b0;
			req_cnt    <= '0;
			rcv_cnt    <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (miss) begin
						state      <= FILL;                 // busy rises next cycle
						req_active <= 1'b1;                 // first read goes out with it
						req_cnt    <= '0;
						rcv_cnt    <= '0;
					end
				end
				FILL: begin
					if (req_active) begin
						req_cnt <= req_cnt + 1'b1;          // one read per cycle
						if (req_cnt == LAST_WORD)
							req_active <= 1'b0;             // eighth read issued
					end
					if (mem_rvalid) begin
						rcv_cnt <= rcv_cnt + 1'b1;          // returns come back in order
						if (rcv_cnt == LAST_WORD)
							state <= DONE;                  // whole block is in the array
					end
				end
				DONE: begin
					state <= IDLE;                          // tag written this cycle
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// block address, only loaded when a fill starts
	always_ff @(posedge clk) begin
		if (state == IDLE && miss) begin
			blk_tag <= miss_addr.tag;
			blk_set <= miss_addr.set_index;
		end
	end

	assign busy            = (state != IDLE);
	assign fill_read       = (state == FILL) && req_active;
	assign fill_write_data = (state == FILL) && mem_rvalid; // store word as it arrives
	assign write_tag       = (state == DONE);               // doubles as finish
	assign fill_word       = rcv_cnt;

	always_comb begin
		fill_addr.tag       = blk_tag;
		fill_addr.set_index = blk_set;
		fill_addr.word_sel  = req_cnt;   // word being requested this cycle
		fill_addr.byte_sel  = 1'b0;      // word aligned
	end

endmodule

// ==== hw/cache_pkg.sv ====
package cache_pkg;

	// bus widths
	localparam int ADDR_W = 16;            // processor byte address
	localparam int DATA_W = 16;            // one word on every bus

	// cache geometry
	localparam int NUM_SETS        = 128;  // direct mapped, one block per set
	localparam int WORDS_PER_BLOCK = 8;    // 16 bytes per block
	localparam int TAG_W           = 5;    // addr[15:11]
	localparam int SET_W           = 7;    // addr[10:4]
	localparam int WORD_W          = 3;    // addr[3:1]

	// byte address as the cache sees it
	// tttt tsss ssss wwwb
	typedef struct packed {
		logic [TAG_W-1:0]  tag;            // compared against meta entry
		logic [SET_W-1:0]  set_index;      // picks the line
		logic [WORD_W-1:0] word_sel;       // picks the word in the block
		logic              byte_sel;       // word accesses only so ignored
	} addr_fields_t;

	// one line of tag storage
	typedef struct packed {
		logic             valid;           // cleared by reset
		logic [TAG_W-1:0] tag;             // tag of the resident block
	} meta_entry_t;

	// command from cache to main memory
	// read and write never high together
	typedef struct packed {
		logic              read;           // fill read, one word per cycle
		logic              write;          // write-through on a write hit
		logic [ADDR_W-1:0] addr;           // byte address
		logic [DATA_W-1:0] wdata;          // only meaningful with write
	} mem_req_t;

endpackage
